// ==== verilog.f ====
+incdir+logic
logic/axil_pkg.sv
logic/demux_pkg.sv
logic/select_fifo.sv
logic/write_demux.sv
logic/read_demux.sv
logic/axil_demux.sv
sim/tb_target_model.sv
sim/tb_axil_demux.sv

// ==== Bender.yml ====
package:
  name: axil_demux

sources:
  - include_dirs:
      - logic
    files:
      - logic/axil_pkg.sv
      - logic/demux_pkg.sv
      - logic/select_fifo.sv
      - logic/write_demux.sv
      - logic/read_demux.sv
      - logic/axil_demux.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tb_target_model.sv
      - sim/tb_axil_demux.sv

// ==== sim/tb_axil_demux.sv ====
/*
  Testbench for the AXI4-Lite demux. A table of writes and reads is issued
  upstream, a target model answers on each port and every transfer is checked.
*/
`timescale 1ns/1ps
`include "demux_macros.svh"

module tb_axil_demux;
  import axil_pkg::*;
  import demux_pkg::*;

  localparam int num_rows       = 16;
  localparam int timeout_cycles = num_rows * 40;

  typedef enum {CH_AW, CH_W, CH_AR} chan_e;

  // one table row with its expected response and read data
  typedef struct packed {
    logic       is_write;
    port_sel_t  sel;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    axil_resp_e exp_resp;
    data_t      exp_rdata;
  } row_t;

  logic                       clk = 1'b0;
  logic                       arst_n = 1'b0;
  axil_req_t                  slv_req;
  axil_rsp_t                  slv_rsp;
  port_sel_t                  aw_sel;
  port_sel_t                  ar_sel;
  axil_req_t [`NUM_PORTS-1:0] mst_reqs;
  axil_rsp_t [`NUM_PORTS-1:0] mst_rsps;
  logic [31:0]                noise [`NUM_PORTS+1];
  row_t                       rows [num_rows];
  int                         write_rows [$];
  int                         read_rows [$];
  int                         num_writes;
  int                         num_reads;
  int                         aw_row;
  int                         w_row;
  int                         ar_row;
  int                         aw_count;
  int                         w_count;
  int                         ar_count;
  int                         b_count;
  int                         r_count;
  logic                       all_issued;

  axil_demux dut0 (
    .clk_i        ( clk      ),
    .arst_n_i     ( arst_n   ),
    .slv_req_i    ( slv_req  ),
    .slv_aw_sel_i ( aw_sel   ),
    .slv_ar_sel_i ( ar_sel   ),
    .slv_rsp_o    ( slv_rsp  ),
    .mst_reqs_o   ( mst_reqs ),
    .mst_rsps_i   ( mst_rsps )
  );

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_targets
    tb_target_model #(
      .port_idx ( i           )
    ) i_target (
      .clk_i    ( clk         ),
      .arst_n_i ( arst_n      ),
      .req_i    ( mst_reqs[i] ),
      .noise_i  ( noise[i]    ),
      .rsp_o    ( mst_rsps[i] )
    );
  end

  // --------------------
  // stimulus table
  task automatic load_table();
    rows[0]  = '{1'b0, 2'd1, 16'h0010, 32'h0,         4'h0, OKAY,   32'h0100_0010};
    rows[1]  = '{1'b1, 2'd2, 16'h0120, 32'ha5a5_0001, 4'hf, OKAY,   32'h0};
    rows[2]  = '{1'b0, 2'd3, 16'h8230, 32'h0,         4'h0, SLVERR, 32'h0300_8230};
    rows[3]  = '{1'b1, 2'd0, 16'h8004, 32'h1234_5678, 4'h3, SLVERR, 32'h0};
    rows[4]  = '{1'b0, 2'd0, 16'h0344, 32'h0,         4'h0, OKAY,   32'h0000_0344};
    rows[5]  = '{1'b1, 2'd1, 16'h0458, 32'hdead_beef, 4'hc, OKAY,   32'h0};
    rows[6]  = '{1'b0, 2'd2, 16'hc56c, 32'h0,         4'h0, SLVERR, 32'h0200_c56c};
    rows[7]  = '{1'b1, 2'd3, 16'h4670, 32'h0f0f_f0f0, 4'h5, OKAY,   32'h0};
    rows[8]  = '{1'b0, 2'd1, 16'h7784, 32'h0,         4'h0, OKAY,   32'h0100_7784};
    rows[9]  = '{1'b1, 2'd2, 16'h9898, 32'h8765_4321, 4'ha, SLVERR, 32'h0};
    rows[10] = '{1'b0, 2'd0, 16'hf9ac, 32'h0,         4'h0, SLVERR, 32'h0000_f9ac};
    rows[11] = '{1'b1, 2'd0, 16'h0abc, 32'h0000_ffff, 4'hf, OKAY,   32'h0};
    rows[12] = '{1'b0, 2'd3, 16'h1bc0, 32'h0,         4'h0, OKAY,   32'h0300_1bc0};
    rows[13] = '{1'b1, 2'd1, 16'hfcd4, 32'hcafe_f00d, 4'h1, SLVERR, 32'h0};
    rows[14] = '{1'b0, 2'd2, 16'h2de8, 32'h0,         4'h0, OKAY,   32'h0200_2de8};
    rows[15] = '{1'b1, 2'd3, 16'haefc, 32'h5555_aaaa, 4'h8, SLVERR, 32'h0};
    foreach (rows[k]) begin
      if (rows[k].is_write) begin
        write_rows.push_back(k);
      end else begin
        read_rows.push_back(k);
      end
    end
    num_writes = write_rows.size();
    num_reads  = read_rows.size();
  endtask

  // --------------------
  // checking
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_aw(input string name, input axil_aw_t exp, input axil_aw_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_ar(input string name, input axil_ar_t exp, input axil_ar_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_w(input string name, input axil_w_t exp, input axil_w_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_b(input string name, input axil_b_t exp, input axil_b_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_r(input string name, input axil_r_t exp, input axil_r_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    end
  endtask

  // runs mid-cycle while all inputs and outputs are settled
  task automatic watch_channels();
    axil_aw_t exp_aw;
    axil_w_t  exp_w;
    axil_ar_t exp_ar;
    axil_b_t  exp_b;
    axil_r_t  exp_r;
    exp_aw = '{addr: rows[aw_row].addr, prot: 3'b000};
    exp_w  = '{data: rows[w_row].data, strb: rows[w_row].strb};
    exp_ar = '{addr: rows[ar_row].addr, prot: 3'b000};
    for (int i = 0; i < `NUM_PORTS; i++) begin
      if (mst_reqs[i].wr.aw_valid) begin
        if (!slv_req.wr.aw_valid || rows[aw_row].sel != port_sel_t'(i)) begin
          report_failure($sformatf("aw_valid raised on port %0d outside its write", i));
        end
        check_aw($sformatf("port %0d aw", i), exp_aw, mst_reqs[i].wr.aw);
      end
      if (mst_reqs[i].wr.w_valid) begin
        if (!slv_req.wr.w_valid || rows[w_row].sel != port_sel_t'(i)) begin
          report_failure($sformatf("w_valid raised on port %0d outside its write", i));
        end
        check_w($sformatf("port %0d w", i), exp_w, mst_reqs[i].wr.w);
      end
      if (mst_reqs[i].rd.ar_valid) begin
        if (!slv_req.rd.ar_valid || rows[ar_row].sel != port_sel_t'(i)) begin
          report_failure($sformatf("ar_valid raised on port %0d outside its read", i));
        end
        check_ar($sformatf("port %0d ar", i), exp_ar, mst_reqs[i].rd.ar);
      end
      // only the port owing the oldest response may see a ready
      if (mst_reqs[i].wr.b_ready) begin
        if (!slv_req.wr.b_ready || b_count >= num_writes ||
            rows[write_rows[b_count]].sel != port_sel_t'(i)) begin
          report_failure($sformatf("b_ready raised on port %0d outside its response", i));
        end
      end
      if (mst_reqs[i].rd.r_ready) begin
        if (!slv_req.rd.r_ready || r_count >= num_reads ||
            rows[read_rows[r_count]].sel != port_sel_t'(i)) begin
          report_failure($sformatf("r_ready raised on port %0d outside its response", i));
        end
      end
    end
    if ((ar_count - r_count) == `MAX_TRANS && slv_rsp.rd.ar_ready) begin
      report_failure("ar_ready is high although the read limit is reached");
    end
    // count upstream transfers that complete at the coming edge
    if (slv_req.wr.aw_valid && slv_rsp.wr.aw_ready) begin
      aw_count++;
    end
    if (slv_req.wr.w_valid && slv_rsp.wr.w_ready) begin
      w_count++;
    end
    if (slv_req.rd.ar_valid && slv_rsp.rd.ar_ready) begin
      ar_count++;
    end
    if (slv_rsp.wr.b_valid && slv_req.wr.b_ready) begin
      if (b_count >= num_writes) begin
        report_failure("a B response arrived with no write outstanding");
      end
      exp_b.resp = rows[write_rows[b_count]].exp_resp;
      check_b("slv b", exp_b, slv_rsp.wr.b);
      b_count++;
    end
    if (slv_rsp.rd.r_valid && slv_req.rd.r_ready) begin
      if (r_count >= num_reads) begin
        report_failure("an R response arrived with no read outstanding");
      end
      exp_r = '{data: rows[read_rows[r_count]].exp_rdata,
                resp: rows[read_rows[r_count]].exp_resp};
      check_r("slv r", exp_r, slv_rsp.rd.r);
      r_count++;
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      watch_channels();
    end
  end

  // --------------------
  // clock, random draws and timeout
  initial begin
    forever #50 clk = ~clk;
  end

  // draws for target back-pressure and the upstream response readies
  initial begin
    noise[0] = $urandom(32'h24cf02f3);
    forever begin
      for (int i = 0; i <= `NUM_PORTS; i++) begin
        noise[i] = $urandom;
      end
      @(negedge clk);
    end
  end

  initial begin
    for (int cycle = 1; cycle <= timeout_cycles; cycle++) begin
      @(posedge clk);
    end
    report_failure("Timeout: not every transfer finished within the cycle limit");
  end

  // --------------------
  // upstream driver
  task automatic hold_until_accepted(input chan_e chan);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      case (chan)
        CH_AW:   taken = slv_rsp.wr.aw_ready;
        CH_W:    taken = slv_rsp.wr.w_ready;
        default: taken = slv_rsp.rd.ar_ready;
      endcase
      @(posedge clk);
      #10;
    end
  endtask

  // write data beats in write order
  initial begin
    @(posedge arst_n);
    foreach (write_rows[n]) begin
      w_row               = write_rows[n];
      slv_req.wr.w        = '{data: rows[w_row].data, strb: rows[w_row].strb};
      slv_req.wr.w_valid  = 1'b1;
      hold_until_accepted(CH_W);
      slv_req.wr.w_valid  = 1'b0;
    end
  end

  // responses wait until the FIFOs filled up or every row is out
  initial begin
    @(posedge arst_n);
    do begin
      @(posedge clk);
    end while (!(all_issued || (ar_count - r_count) == `MAX_TRANS ||
                 (aw_count - b_count) == 2 * `MAX_TRANS));
    forever begin
      #10;
      slv_req.wr.b_ready = noise[`NUM_PORTS][0];
      slv_req.rd.r_ready = noise[`NUM_PORTS][1];
      @(posedge clk);
    end
  end

  initial begin
    slv_req    = '0;
    aw_sel     = '0;
    ar_sel     = '0;
    aw_row     = 0;
    w_row      = 0;
    ar_row     = 0;
    aw_count   = 0;
    w_count    = 0;
    ar_count   = 0;
    b_count    = 0;
    r_count    = 0;
    all_issued = 1'b0;
    load_table();
    repeat (5) @(posedge clk);
    #10;
    arst_n = 1'b1;
    // address requests in table order
    for (int k = 0; k < num_rows; k++) begin
      if (rows[k].is_write) begin
        aw_row              = k;
        aw_sel              = rows[k].sel;
        slv_req.wr.aw       = '{addr: rows[k].addr, prot: 3'b000};
        slv_req.wr.aw_valid = 1'b1;
        hold_until_accepted(CH_AW);
        slv_req.wr.aw_valid = 1'b0;
      end else begin
        ar_row              = k;
        ar_sel              = rows[k].sel;
        slv_req.rd.ar       = '{addr: rows[k].addr, prot: 3'b000};
        slv_req.rd.ar_valid = 1'b1;
        hold_until_accepted(CH_AR);
        slv_req.rd.ar_valid = 1'b0;
      end
    end
    all_issued = 1'b1;
    wait (b_count == num_writes && r_count == num_reads);
    @(negedge clk);
    if (aw_count == num_writes && w_count == num_writes && ar_count == num_reads &&
        !slv_rsp.wr.b_valid && !slv_rsp.rd.r_valid) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_failure("Transfer counts do not match the table at the end of the run");
    end
  end

endmodule

// ==== sim/tb_target_model.sv ====
/*
  Downstream AXI4-Lite target for the demux testbench, one per port.
  Readies and response delays follow the noise input. Responses leave in order.
*/
`timescale 1ns/1ps

module tb_target_model #(
  parameter int unsigned port_idx = 0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  axil_pkg::axil_req_t req_i,
  input  logic [31:0]         noise_i,
  output axil_pkg::axil_rsp_t rsp_o
);
  import axil_pkg::*;

  addr_t       aw_q [$];
  addr_t       ar_q [$];
  axil_resp_e  b_q [$];
  int unsigned w_beats;
  addr_t       aw_addr;
  addr_t       ar_addr;
  addr_t       rd_addr;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        ar_hs;
  logic        r_hs;

  // upper half of the address map answers with an error
  function automatic axil_resp_e resp_for(input addr_t addr);
    return addr[15] ? SLVERR : OKAY;
  endfunction

  initial begin
    rsp_o   = '0;
    w_beats = 0;
    forever begin
      // transfers that complete at the coming edge
      @(negedge clk_i);
      aw_hs   = req_i.wr.aw_valid & rsp_o.wr.aw_ready;
      w_hs    = req_i.wr.w_valid & rsp_o.wr.w_ready;
      b_hs    = rsp_o.wr.b_valid & req_i.wr.b_ready;
      ar_hs   = req_i.rd.ar_valid & rsp_o.rd.ar_ready;
      r_hs    = rsp_o.rd.r_valid & req_i.rd.r_ready;
      aw_addr = req_i.wr.aw.addr;
      ar_addr = req_i.rd.ar.addr;
      @(posedge clk_i);
      #10;
      if (aw_hs) begin
        aw_q.push_back(aw_addr);
      end
      if (w_hs) begin
        w_beats++;
      end
      if (ar_hs) begin
        ar_q.push_back(ar_addr);
      end
      // a write is complete once both its address and its data arrived
      while (aw_q.size() > 0 && w_beats > 0) begin
        b_q.push_back(resp_for(aw_q.pop_front()));
        w_beats--;
      end
      if (b_hs) begin
        rsp_o.wr.b_valid = 1'b0;
      end
      if (r_hs) begin
        rsp_o.rd.r_valid = 1'b0;
      end
      // a raised valid stays until taken, a new one comes after a random delay
      if (!rsp_o.wr.b_valid && b_q.size() > 0 && noise_i[3]) begin
        rsp_o.wr.b.resp  = b_q.pop_front();
        rsp_o.wr.b_valid = 1'b1;
      end
      if (!rsp_o.rd.r_valid && ar_q.size() > 0 && noise_i[4]) begin
        rd_addr          = ar_q.pop_front();
        // port index in the top byte and the address in the low half
        rsp_o.rd.r.data  = {8'(port_idx), 8'h00, rd_addr};
        rsp_o.rd.r.resp  = resp_for(rd_addr);
        rsp_o.rd.r_valid = 1'b1;
      end
      rsp_o.wr.aw_ready = arst_n_i & noise_i[0];
      rsp_o.wr.w_ready  = arst_n_i & noise_i[1];
      rsp_o.rd.ar_ready = arst_n_i & noise_i[2];
    end
  end

endmodule

// ==== logic/axil_demux.sv ====
/*
  AXI4-Lite demux top level. One upstream port fans out to NUM_PORTS
  downstream ports, picked per AW and AR by the select inputs.
*/
`timescale 1ns/1ps
`include "demux_macros.svh"

module axil_demux (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  axil_pkg::axil_req_t                  slv_req_i,
  input  demux_pkg::port_sel_t                 slv_aw_sel_i,
  input  demux_pkg::port_sel_t                 slv_ar_sel_i,
  output axil_pkg::axil_rsp_t                  slv_rsp_o,
  output axil_pkg::axil_req_t [`NUM_PORTS-1:0] mst_reqs_o,
  input  axil_pkg::axil_rsp_t [`NUM_PORTS-1:0] mst_rsps_i
);
  import axil_pkg::*;

  axil_wr_req_t [`NUM_PORTS-1:0] mst_wr_reqs;
  axil_wr_rsp_t [`NUM_PORTS-1:0] mst_wr_rsps;
  axil_rd_req_t [`NUM_PORTS-1:0] mst_rd_reqs;
  axil_rd_rsp_t [`NUM_PORTS-1:0] mst_rd_rsps;

  // split and join the per-port buses
  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_ports
    assign mst_reqs_o[i].wr = mst_wr_reqs[i];
    assign mst_reqs_o[i].rd = mst_rd_reqs[i];
    assign mst_wr_rsps[i]   = mst_rsps_i[i].wr;
    assign mst_rd_rsps[i]   = mst_rsps_i[i].rd;
  end

  write_demux i_write_demux (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .wr_req_i      ( slv_req_i.wr  ),
    .aw_sel_i      ( slv_aw_sel_i  ),
    .wr_rsp_o      ( slv_rsp_o.wr  ),
    .mst_wr_reqs_o ( mst_wr_reqs   ),
    .mst_wr_rsps_i ( mst_wr_rsps   )
  );

  read_demux i_read_demux (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .rd_req_i      ( slv_req_i.rd  ),
    .ar_sel_i      ( slv_ar_sel_i  ),
    .rd_rsp_o      ( slv_rsp_o.rd  ),
    .mst_rd_reqs_o ( mst_rd_reqs   ),
    .mst_rd_rsps_i ( mst_rd_rsps   )
  );

endmodule

// ==== logic/read_demux.sv ====
/*
  Read half of the AXI4-Lite demux. AR goes to the selected port and
  R data returns in issue order from the head of the R select FIFO.
*/
`timescale 1ns/1ps
`include "demux_macros.svh"

module read_demux (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  axil_pkg::axil_rd_req_t                  rd_req_i,
  input  demux_pkg::port_sel_t                    ar_sel_i,
  output axil_pkg::axil_rd_rsp_t                  rd_rsp_o,
  output axil_pkg::axil_rd_req_t [`NUM_PORTS-1:0] mst_rd_reqs_o,
  input  axil_pkg::axil_rd_rsp_t [`NUM_PORTS-1:0] mst_rd_rsps_i
);
  import axil_pkg::*;
  import demux_pkg::*;

  logic      slv_ar_ready;
  logic      r_fifo_push;
  logic      r_fifo_pop;
  logic      r_fifo_full;
  logic      r_fifo_empty;
  port_sel_t r_sel;
  axil_r_t   slv_r;
  logic      slv_r_valid;

  // --------------------
  // AR channel
  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_mst_ar
    assign mst_rd_reqs_o[i].ar       = rd_req_i.ar;
    assign mst_rd_reqs_o[i].ar_valid = ~r_fifo_full & rd_req_i.ar_valid &
                                       (ar_sel_i == port_sel_t'(i));
  end

  // a full R FIFO stalls new reads
  assign slv_ar_ready      = ~r_fifo_full & mst_rd_rsps_i[ar_sel_i].ar_ready;
  assign rd_rsp_o.ar_ready = slv_ar_ready;
  assign r_fifo_push       = rd_req_i.ar_valid & slv_ar_ready;

  select_fifo #(
    .depth    ( `MAX_TRANS   )
  ) i_r_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( r_fifo_push  ),
    .sel_i    ( ar_sel_i     ),
    .pop_i    ( r_fifo_pop   ),
    .sel_o    ( r_sel        ),
    .full_o   ( r_fifo_full  ),
    .empty_o  ( r_fifo_empty )
  );

  // --------------------
  // R channel
  // only the oldest outstanding read may answer
  always_comb begin
    slv_r       = '0;
    slv_r_valid = 1'b0;
    if (!r_fifo_empty) begin
      slv_r       = mst_rd_rsps_i[r_sel].r;
      slv_r_valid = mst_rd_rsps_i[r_sel].r_valid;
    end
  end

  assign rd_rsp_o.r       = slv_r;
  assign rd_rsp_o.r_valid = slv_r_valid;

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_mst_r
    assign mst_rd_reqs_o[i].r_ready = ~r_fifo_empty & rd_req_i.r_ready &
                                      (r_sel == port_sel_t'(i));
  end

  assign r_fifo_pop = slv_r_valid & rd_req_i.r_ready;

endmodule

// ==== logic/write_demux.sv ====
/*
  Write half of the AXI4-Lite demux. AW is routed by the request select,
  W by the head of the W select FIFO and B comes back from the B FIFO head.
*/
`timescale 1ns/1ps
`include "demux_macros.svh"

module write_demux (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  axil_pkg::axil_wr_req_t                  wr_req_i,
  input  demux_pkg::port_sel_t                    aw_sel_i,
  output axil_pkg::axil_wr_rsp_t                  wr_rsp_o,
  output axil_pkg::axil_wr_req_t [`NUM_PORTS-1:0] mst_wr_reqs_o,
  input  axil_pkg::axil_wr_rsp_t [`NUM_PORTS-1:0] mst_wr_rsps_i
);
  import axil_pkg::*;
  import demux_pkg::*;

  aw_state_e             aw_state_q;
  aw_state_e             aw_state_d;
  logic [`NUM_PORTS-1:0] mst_aw_valids;
  logic [`NUM_PORTS-1:0] mst_aw_readies;
  logic                  slv_aw_ready;
  logic                  w_fifo_push;
  logic                  w_fifo_pop;
  logic                  w_fifo_full;
  logic                  w_fifo_empty;
  port_sel_t             w_sel;
  logic                  w_enable;
  logic                  slv_w_ready;
  logic                  b_fifo_pop;
  logic                  b_fifo_full;
  logic                  b_fifo_empty;
  port_sel_t             b_sel;
  axil_b_t               slv_b;
  logic                  slv_b_valid;

  // --------------------
  // AW channel
  // address goes to every port and valid only to the selected one
  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_mst_aw
    assign mst_wr_reqs_o[i].aw       = wr_req_i.aw;
    assign mst_wr_reqs_o[i].aw_valid = mst_aw_valids[i];
    assign mst_aw_readies[i]         = mst_wr_rsps_i[i].aw_ready;
  end

  always_comb begin
    aw_state_d    = aw_state_q;
    slv_aw_ready  = 1'b0;
    mst_aw_valids = '0;
    w_fifo_push   = 1'b0;
    case (aw_state_q)
      AW_IDLE: begin
        // new write is only offered while the W FIFO has room
        if (!w_fifo_full && wr_req_i.aw_valid) begin
          w_fifo_push             = 1'b1;
          mst_aw_valids[aw_sel_i] = 1'b1;
          if (mst_aw_readies[aw_sel_i]) begin
            slv_aw_ready = 1'b1;
          end else begin
            aw_state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        // select already pushed, hold valid without pushing again
        mst_aw_valids[aw_sel_i] = 1'b1;
        if (mst_aw_readies[aw_sel_i]) begin
          slv_aw_ready = 1'b1;
          aw_state_d   = AW_IDLE;
        end
      end
      default: aw_state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_state_q <= AW_IDLE;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

  assign wr_rsp_o.aw_ready = slv_aw_ready;

  select_fifo #(
    .depth    ( `MAX_TRANS   )
  ) i_w_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( w_fifo_push  ),
    .sel_i    ( aw_sel_i     ),
    .pop_i    ( w_fifo_pop   ),
    .sel_o    ( w_sel        ),
    .full_o   ( w_fifo_full  ),
    .empty_o  ( w_fifo_empty )
  );

  // --------------------
  // W channel
  // a beat needs a known target and room to record its response
  assign w_enable = ~w_fifo_empty & ~b_fifo_full;

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_mst_w
    assign mst_wr_reqs_o[i].w       = wr_req_i.w;
    assign mst_wr_reqs_o[i].w_valid = w_enable & wr_req_i.w_valid &
                                      (w_sel == port_sel_t'(i));
  end

  assign slv_w_ready      = w_enable & mst_wr_rsps_i[w_sel].w_ready;
  assign wr_rsp_o.w_ready = slv_w_ready;
  assign w_fifo_pop       = wr_req_i.w_valid & slv_w_ready;

  // each transferred beat hands its select over to the B side
  select_fifo #(
    .depth    ( `MAX_TRANS   )
  ) i_b_fifo (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .push_i   ( w_fifo_pop   ),
    .sel_i    ( w_sel        ),
    .pop_i    ( b_fifo_pop   ),
    .sel_o    ( b_sel        ),
    .full_o   ( b_fifo_full  ),
    .empty_o  ( b_fifo_empty )
  );

  // --------------------
  // B channel
  always_comb begin
    slv_b       = '0;
    slv_b_valid = 1'b0;
    if (!b_fifo_empty) begin
      slv_b       = mst_wr_rsps_i[b_sel].b;
      slv_b_valid = mst_wr_rsps_i[b_sel].b_valid;
    end
  end

  assign wr_rsp_o.b       = slv_b;
  assign wr_rsp_o.b_valid = slv_b_valid;

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gen_mst_b
    assign mst_wr_reqs_o[i].b_ready = ~b_fifo_empty & wr_req_i.b_ready &
                                      (b_sel == port_sel_t'(i));
  end

  assign b_fifo_pop = slv_b_valid & wr_req_i.b_ready;

endmodule

// ==== logic/select_fifo.sv ====
/*
  Registered FIFO of port selects, one entry per outstanding transaction.
  Responses are routed back in the order the selects were pushed.
*/
`timescale 1ns/1ps

module select_fifo #(
  parameter int unsigned depth = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 push_i,
  input  demux_pkg::port_sel_t sel_i,
  input  logic                 pop_i,
  output demux_pkg::port_sel_t sel_o,
  output logic                 full_o,
  output logic                 empty_o
);
  import demux_pkg::*;

  localparam int unsigned ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_width = $clog2(depth + 1);

  port_sel_t            mem_q [depth];
  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [cnt_width-1:0] count_q;
  logic                 do_push;
  logic                 do_pop;

  assign full_o  = (count_q == cnt_width'(depth));
  assign empty_o = (count_q == '0);
  assign sel_o   = mem_q[rd_ptr_q];

  // requests against a full or empty buffer are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= sel_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_width'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_width'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== logic/demux_pkg.sv ====
/*
  Routing types of the demux: the port select and the AW lock state.
*/
`include "demux_macros.svh"

package demux_pkg;

  // index of a downstream port
  typedef logic [$clog2(`NUM_PORTS)-1:0] port_sel_t;

  // --------------------
  // AW lock
  // locked means the select is already in the W FIFO and the
  // chosen port still owes its aw_ready
  typedef enum logic {
    AW_IDLE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_state_e;

endpackage

// ==== logic/axil_pkg.sv ====
/*
  AXI4-Lite channel payloads and the request/response structs that bundle them.
  Write and read halves are separate so each demux half owns its own fields.
*/
`include "demux_macros.svh"

package axil_pkg;

  localparam int unsigned STRB_WIDTH = `DATA_WIDTH / 8;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0]  strb_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // --------------------
  // channel payloads
  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } axil_aw_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } axil_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    data_t      data;
    axil_resp_e resp;
  } axil_r_t;

  // --------------------
  // write and read halves
  typedef struct packed {
    axil_aw_t aw;
    logic     aw_valid;
    axil_w_t  w;
    logic     w_valid;
    logic     b_ready;
  } axil_wr_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    axil_b_t b;
    logic    b_valid;
  } axil_wr_rsp_t;

  typedef struct packed {
    axil_ar_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_rd_req_t;

  typedef struct packed {
    logic    ar_ready;
    axil_r_t r;
    logic    r_valid;
  } axil_rd_rsp_t;

  // full bus, as seen at a port
  typedef struct packed {
    axil_wr_req_t wr;
    axil_rd_req_t rd;
  } axil_req_t;

  typedef struct packed {
    axil_wr_rsp_t wr;
    axil_rd_rsp_t rd;
  } axil_rsp_t;

endpackage

// ==== logic/demux_macros.svh ====
/*
  Sizing constants for the AXI4-Lite demux.
  Included by both packages, the RTL and the testbench.
*/
`ifndef DEMUX_MACROS_SVH
`define DEMUX_MACROS_SVH

// number of downstream ports (two or more)
`define NUM_PORTS 4

// outstanding transactions tracked per select FIFO
`define MAX_TRANS 4

// bus widths
`define ADDR_WIDTH 16
`define DATA_WIDTH 32

`endif
